/* src/tcdm_pkg.sv */
// tcdm package: widths, bank size and the request and response payloads of the TCDM path.
`default_nettype none

package tcdm_pkg;

  // data word and byte-enable widths.
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8; // one enable per byte lane.

  // byte address width; the two low bits select a byte inside the word.
  localparam int unsigned ADDR_W = 10;

  // bank depth in words, and the width of the word index taken from the address.
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned WORD_IDX_W = $clog2(BANK_WORDS);

  // number of initiator ports sharing the bank.
  localparam int unsigned N_INIT = 2;
  localparam int unsigned ID_W   = $clog2(N_INIT); // one bit tags initiator 0 or 1.

  // request payload as it travels from the arbiter to the bank.
  // wen high is a read and wen low is a write, as on the TCDM bus.
  typedef struct packed {
    logic [ADDR_W-1:0] add;  // byte address.
    logic [DATA_W-1:0] data; // write data, ignored on reads.
    logic [BE_W-1:0]   be;   // byte enables for writes.
    logic              wen;  // 1 = read, 0 = write.
    logic [ID_W-1:0]   id;   // initiator that issued the request.
  } tcdm_req_t;

  // response payload returned from the bank towards the initiators.
  typedef struct packed {
    logic [DATA_W-1:0] r_data; // read word.
    logic [ID_W-1:0]   r_id;   // initiator that the response belongs to.
  } tcdm_resp_t;

endpackage : tcdm_pkg

`default_nettype wire

/* src/tcdm_reg_slice.sv */
// tcdm register slice: one pipeline stage holding a valid strobe and its payload.
`timescale 1ns/1ps
`default_nettype none

module tcdm_reg_slice #(
  parameter type payload_t = logic [31:0] // the payload carried by this stage.
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_in,  // single-cycle strobe from the previous stage.
  input  payload_t data_in,   // payload qualified by valid_in.
  output logic     valid_out, // strobe delayed by one cycle.
  output payload_t data_out   // payload of the last valid beat.
);

  // the valid strobe is control state and must come out of reset low.
  // there is no back-pressure, so every incoming strobe simply moves on
  // one cycle later.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  // the payload only loads on a valid beat.
  // between beats it keeps its old value, so the downstream logic does not
  // toggle for nothing.
  always_ff @(posedge clk_i) begin
    if (valid_in) begin
      data_out <= data_in; // capture the beat that is moving through.
    end
  end

endmodule : tcdm_reg_slice

`default_nettype wire

/* src/tcdm_arbiter.sv */
// tcdm arbiter: round-robin grant of one of two initiator requests per cycle.
`timescale 1ns/1ps
`default_nettype none

module tcdm_arbiter import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_0,
  input  logic              req_1,
  input  logic [ADDR_W-1:0] add_0,
  input  logic [ADDR_W-1:0] add_1,
  input  logic [DATA_W-1:0] data_0,
  input  logic [DATA_W-1:0] data_1,
  input  logic [BE_W-1:0]   be_0,
  input  logic [BE_W-1:0]   be_1,
  input  logic              wen_0,
  input  logic              wen_1,
  output logic              gnt_0,
  output logic              gnt_1,
  output logic              req_valid,  // one transfer is granted in this cycle.
  output tcdm_req_t         req_payload // fields of the granted transfer.
);

  logic            rr_q;      // priority pointer; 0 favours initiator 0, 1 favours initiator 1.
  logic            contended; // both initiators request in the same cycle.
  logic            sel_1;     // initiator 1 wins this cycle.
  logic [ID_W-1:0] win_id;    // id of the winning initiator.

  assign contended = req_0 & req_1;

  // a lone requester is granted straight away.
  // under contention the pointer decides.
  assign gnt_0 = req_0 & (~req_1 | ~rr_q);
  assign gnt_1 = req_1 & (~req_0 |  rr_q);

  assign sel_1  = gnt_1;
  assign win_id = ID_W'(sel_1); // initiator 1 gets id 1, initiator 0 gets id 0.

  // the bank always accepts, so any request present gives a transfer.
  assign req_valid = req_0 | req_1;

  // the payload is taken from the winner.
  // with no request the fields of initiator 0 pass through, and
  // req_valid is low so nobody looks at them.
  always_comb begin
    if (sel_1) begin
      req_payload.add  = add_1;
      req_payload.data = data_1;
      req_payload.be   = be_1;
      req_payload.wen  = wen_1;
    end else begin
      req_payload.add  = add_0;
      req_payload.data = data_0;
      req_payload.be   = be_0;
      req_payload.wen  = wen_0;
    end
    req_payload.id = win_id; // tag used later to steer the response back.
  end

  // the pointer only moves after a contended grant.
  // it turns away from the initiator that just won, so the loser goes
  // first next time.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0; // initiator 0 has priority after reset.
    end else if (contended) begin
      rr_q <= ~sel_1;
    end
  end

  // at most one initiator may own the bank in any cycle.
  a_onehot_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(gnt_0 && gnt_1))
    else $error("arbiter granted both initiators in one cycle");

endmodule : tcdm_arbiter

`default_nettype wire

/* src/tcdm_r_valid_filter.sv */
// tcdm response-valid filter: suppresses bank response strobes that belong to writes.
`timescale 1ns/1ps
`default_nettype none

module tcdm_r_valid_filter import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear,       // drops the stored request kind.
  input  logic              enable,      // filtering is active.
  input  logic              in_req,      // request strobe from the request slice.
  input  tcdm_req_t         in_payload,  // request fields from the request slice.
  output logic              mem_req,
  output logic              mem_wen,
  output logic [ADDR_W-1:0] mem_add,
  output logic [DATA_W-1:0] mem_data,
  output logic [BE_W-1:0]   mem_be,
  output logic [ID_W-1:0]   mem_id,
  input  logic              mem_r_valid, // bank response strobe, one cycle after mem_req.
  input  logic [DATA_W-1:0] mem_r_data,
  input  logic [ID_W-1:0]   mem_r_id,
  output logic              out_r_valid, // response strobe after filtering.
  output tcdm_resp_t        out_resp
);

  logic wen_q; // kind of the request now being served by the bank; 1 = read.

  // the request side is a straight connection to the bank.
  assign mem_req  = in_req;
  assign mem_wen  = in_payload.wen;
  assign mem_add  = in_payload.add;
  assign mem_data = in_payload.data;
  assign mem_be   = in_payload.be;
  assign mem_id   = in_payload.id;

  // response data and id go back untouched.
  assign out_resp.r_data = mem_r_data;
  assign out_resp.r_id   = mem_r_id;

  // the bank answers exactly one cycle after the request.
  // so the kind stored at the request edge lines up with its response.
  // a write leaves wen_q low and the strobe is removed.
  assign out_r_valid = enable ? (mem_r_valid & wen_q) : mem_r_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wen_q <= 1'b0;
    end else if (clear) begin
      wen_q <= 1'b0; // forget the last request kind.
    end else if (enable && in_req) begin
      wen_q <= in_payload.wen; // remember whether this one is a read.
    end
  end

  // with the filter on, a write must not be answered in the following cycle.
  a_no_write_resp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (enable && in_req && !in_payload.wen) |=> !out_r_valid)
    else $error("filter passed a response valid for a write request");

endmodule : tcdm_r_valid_filter

`default_nettype wire

/* src/tcdm_sram_bank.sv */
// tcdm sram bank: single-ported word memory with byte enables and a one-cycle response.
`timescale 1ns/1ps
`default_nettype none

module tcdm_sram_bank import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req,     // access strobe; the bank never stalls.
  input  logic              wen,     // 1 = read, 0 = write.
  input  logic [ADDR_W-1:0] add,     // byte address.
  input  logic [DATA_W-1:0] data,    // write data.
  input  logic [BE_W-1:0]   be,      // byte enables for writes.
  input  logic [ID_W-1:0]   id,      // initiator tag, returned with the response.
  output logic              r_valid, // one strobe per request, writes included.
  output logic [DATA_W-1:0] r_data,  // last word read.
  output logic [ID_W-1:0]   r_id
);

  logic [DATA_W-1:0]     mem [BANK_WORDS]; // the storage array.
  logic [WORD_IDX_W-1:0] word_idx;         // word index inside the bank.

  // the two low address bits select a byte and are not used for the word.
  assign word_idx = add[WORD_IDX_W+1:2];

  // array access.
  // a write updates only the enabled byte lanes. a read registers the
  // whole word, and r_data keeps its value across writes.
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (!wen) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be[b]) begin
            mem[word_idx][8*b +: 8] <= data[8*b +: 8]; // merge one byte lane.
          end
        end
      end else begin
        r_data <= mem[word_idx];
      end
      r_id <= id; // the tag follows every request.
    end
  end

  // every request, read or write, gets a response strobe one cycle later.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= req;
    end
  end

  // an access must stay inside the bank.
  a_addr_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req |-> (add[ADDR_W-1:2] < BANK_WORDS))
    else $error("bank access outside %0d words, add = 0x%0h", BANK_WORDS, add);

endmodule : tcdm_sram_bank

`default_nettype wire

/* src/tcdm_subsystem.sv */
// tcdm subsystem: two initiators sharing one sram bank through an arbitrated pipeline.
`timescale 1ns/1ps
`default_nettype none

module tcdm_subsystem import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              filter_en, // drop write responses.
  input  logic              clear,     // clear the filter state; only while idle.
  // initiator 0.
  input  logic              req_0,
  input  logic [ADDR_W-1:0] add_0,
  input  logic              wen_0,
  input  logic [BE_W-1:0]   be_0,
  input  logic [DATA_W-1:0] data_0,
  output logic              gnt_0,
  output logic              r_valid_0,
  output logic [DATA_W-1:0] r_data_0,
  // initiator 1.
  input  logic              req_1,
  input  logic [ADDR_W-1:0] add_1,
  input  logic              wen_1,
  input  logic [BE_W-1:0]   be_1,
  input  logic [DATA_W-1:0] data_1,
  output logic              gnt_1,
  output logic              r_valid_1,
  output logic [DATA_W-1:0] r_data_1
);

  logic              arb_valid;   // granted transfer out of the arbiter.
  tcdm_req_t         arb_payload;
  logic              slc_valid;   // request one cycle after the grant.
  tcdm_req_t         slc_payload;
  logic              mem_req;     // request side of the bank.
  logic              mem_wen;
  logic [ADDR_W-1:0] mem_add;
  logic [DATA_W-1:0] mem_data;
  logic [BE_W-1:0]   mem_be;
  logic [ID_W-1:0]   mem_id;
  logic              mem_r_valid; // bank response, two cycles after the grant.
  logic [DATA_W-1:0] mem_r_data;
  logic [ID_W-1:0]   mem_r_id;
  logic              flt_valid;   // response strobe after the write filter.
  tcdm_resp_t        flt_resp;
  logic              rsp_valid;   // response three cycles after the grant.
  tcdm_resp_t        rsp_payload;

  // stage 0: pick one initiator; gnt goes back in the same cycle.
  tcdm_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .req_0, .req_1,
    .add_0, .add_1,
    .data_0, .data_1,
    .be_0, .be_1,
    .wen_0, .wen_1,
    .gnt_0, .gnt_1,
    .req_valid   (arb_valid),
    .req_payload (arb_payload)
  );

  // stage 1: register the granted request.
  tcdm_reg_slice #(.payload_t(tcdm_req_t)) i_req_slice (
    .clk_i, .rst_ni,
    .valid_in  (arb_valid),
    .data_in   (arb_payload),
    .valid_out (slc_valid),
    .data_out  (slc_payload)
  );

  // the filter sits around the bank and adds no latency.
  tcdm_r_valid_filter i_filter (
    .clk_i, .rst_ni,
    .clear,
    .enable      (filter_en),
    .in_req      (slc_valid),
    .in_payload  (slc_payload),
    .mem_req, .mem_wen, .mem_add, .mem_data, .mem_be, .mem_id,
    .mem_r_valid, .mem_r_data, .mem_r_id,
    .out_r_valid (flt_valid),
    .out_resp    (flt_resp)
  );

  // stage 2: the memory itself.
  tcdm_sram_bank i_bank (
    .clk_i, .rst_ni,
    .req     (mem_req),
    .wen     (mem_wen),
    .add     (mem_add),
    .data    (mem_data),
    .be      (mem_be),
    .id      (mem_id),
    .r_valid (mem_r_valid),
    .r_data  (mem_r_data),
    .r_id    (mem_r_id)
  );

  // stage 3: register the response before it leaves the subsystem.
  tcdm_reg_slice #(.payload_t(tcdm_resp_t)) i_resp_slice (
    .clk_i, .rst_ni,
    .valid_in  (flt_valid),
    .data_in   (flt_resp),
    .valid_out (rsp_valid),
    .data_out  (rsp_payload)
  );

  // route the strobe back to the initiator named by the id.
  assign r_valid_0 = rsp_valid & (rsp_payload.r_id == ID_W'(0));
  assign r_valid_1 = rsp_valid & (rsp_payload.r_id == ID_W'(1));
  assign r_data_0  = rsp_payload.r_data; // data is shared; only the strobe is steered.
  assign r_data_1  = rsp_payload.r_data;

endmodule : tcdm_subsystem

`default_nettype wire

/* bench/tb_clock.sv */
// tb clock: free-running testbench clock and an active-low reset held for a few cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS    = 4.0, // full clock period.
  parameter int  RESET_CYCLES = 4    // rising edges seen with reset low.
) (
  output logic clk_i,
  output logic rst_ni
);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_i = ~clk_i;
  end

  // reset is released on a falling edge, well away from the sampling edge.
  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule : tb_clock

`default_nettype wire

/* bench/tb_tcdm_subsystem.sv */
// tcdm subsystem testbench: directed and random traffic on both initiators, checked against a model.
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_subsystem import tcdm_pkg::*; ();

  localparam int unsigned SEED       = 15118;
  localparam int          FILL_WORDS = 16; // words written before anything reads them.
  localparam int          DIRECT_N   = 12; // directed transfers after the fill.
  localparam int          BURST_N    = 20; // single-initiator back-to-back transfers.
  localparam int          RAND_N     = 24; // contended transfers per initiator.
  localparam int          N_TRANS    = FILL_WORDS + DIRECT_N + BURST_N + N_INIT * RAND_N;
  localparam int          TIMEOUT    = N_TRANS * 8 + 100;
  localparam int          LATENCY    = 3; // grant edge to the edge that samples r_valid.

  // one response the model waits for.
  typedef struct packed {
    int                due;  // cycle count of the edge that samples the strobe.
    logic              rd;   // data is only checked for reads.
    logic [DATA_W-1:0] data;
  } exp_t;

  logic              clk_i;
  logic              rst_ni;
  logic              filter_en;
  logic              clear;
  logic [N_INIT-1:0] req;
  logic [N_INIT-1:0] wen;
  logic [ADDR_W-1:0] add    [N_INIT];
  logic [BE_W-1:0]   be     [N_INIT];
  logic [DATA_W-1:0] data   [N_INIT];
  logic [N_INIT-1:0] gnt;
  logic [N_INIT-1:0] r_valid;
  logic [DATA_W-1:0] r_data [N_INIT];

  logic [DATA_W-1:0] ref_mem [BANK_WORDS];   // what the bank should hold.
  exp_t              exp_q   [N_INIT][$];    // outstanding responses per initiator.
  logic [N_INIT-1:0] exp_valid = '0;         // expectation for the next rising edge.
  logic [N_INIT-1:0] exp_read  = '0;
  logic [DATA_W-1:0] exp_data  [N_INIT];
  int                cyc       = 0;          // rising edges seen so far.
  tcdm_req_t         rnd_txn   [N_INIT][RAND_N];
  tcdm_req_t         t;

  tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(4)) clock0 (.clk_i, .rst_ni);

  tcdm_subsystem dut0 (
    .clk_i, .rst_ni, .filter_en, .clear,
    .req_0 (req[0]), .add_0 (add[0]), .wen_0 (wen[0]), .be_0 (be[0]), .data_0 (data[0]),
    .gnt_0 (gnt[0]), .r_valid_0 (r_valid[0]), .r_data_0 (r_data[0]),
    .req_1 (req[1]), .add_1 (add[1]), .wen_1 (wen[1]), .be_1 (be[1]), .data_1 (data[1]),
    .gnt_1 (gnt[1]), .r_valid_1 (r_valid[1]), .r_data_1 (r_data[1])
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [ADDR_W-1:0] word_add(input int unsigned idx);
    return ADDR_W'(idx << 2); // byte address of a word index.
  endfunction

  // every byte lane is a different function of the word index.
  function automatic logic [DATA_W-1:0] fill_word(input int unsigned idx);
    logic [7:0] w;
    w = 8'(idx);
    return {~w, w, 8'h5A ^ w, w + 8'h3C};
  endfunction

  // a request to one of the filled words, with random byte offset bits as well.
  function automatic tcdm_req_t random_txn();
    tcdm_req_t r;
    r.add  = word_add($urandom_range(FILL_WORDS - 1, 0));
    r.add  = r.add | ADDR_W'($urandom_range(3, 0));
    r.data = $urandom();
    r.be   = BE_W'($urandom_range(2 ** BE_W - 1, 0));
    r.wen  = 1'($urandom_range(1, 0));
    r.id   = '0;
    return r;
  endfunction

  // a transfer seen at a rising edge updates the memory and may queue a response.
  function automatic void record_grant(input int p);
    exp_t        e;
    int unsigned w;
    w = add[p][ADDR_W-1:2];
    if (!wen[p]) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[p][b]) ref_mem[w][8*b +: 8] = data[p][8*b +: 8];
      end
    end
    if (wen[p] || !filter_en) begin // writes only answer while the filter is off.
      e.due  = cyc + LATENCY;
      e.rd   = wen[p];
      e.data = ref_mem[w];
      exp_q[p].push_back(e);
    end
  endfunction

  always @(posedge clk_i) begin
    for (int p = 0; p < N_INIT; p++) begin
      if (exp_q[p].size() != 0 && exp_q[p][0].due == cyc) begin
        void'(exp_q[p].pop_front()); // checked by the assertions at this edge.
      end
      if (rst_ni && req[p] && gnt[p]) begin
        record_grant(p);
      end
    end
    cyc = cyc + 1;
  end

  // the queues are stable at the falling edge, so the next expectation is set here.
  always @(negedge clk_i) begin
    for (int p = 0; p < N_INIT; p++) begin
      if (exp_q[p].size() != 0 && exp_q[p][0].due == cyc) begin
        exp_valid[p] = 1'b1;
        exp_read[p]  = exp_q[p][0].rd;
        exp_data[p]  = exp_q[p][0].data;
      end else begin
        exp_valid[p] = 1'b0;
        exp_read[p]  = 1'b0;
      end
    end
    if (cyc >= TIMEOUT) begin
      abort_run($sformatf("timeout: the run did not finish within %0d cycles", TIMEOUT));
    end
  end

  for (genvar p = 0; p < N_INIT; p++) begin : g_resp_check
    a_r_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid[p] == exp_valid[p])
      else report_mismatch($sformatf("r_valid_%0d", p), $sampled(r_valid[p]),
                           $sampled(exp_valid[p]));
    a_r_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (exp_valid[p] && exp_read[p]) |-> (r_data[p] == exp_data[p]))
      else report_mismatch($sformatf("r_data_%0d", p), $sampled(r_data[p]),
                           $sampled(exp_data[p]));
  end

  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni) !(&gnt))
    else abort_run("both initiators were granted in the same cycle");

  // two contended cycles in a row must hand the bank to the other side.
  a_gnt_alternate : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((req == '1) && ($past(req) == '1)) |-> (gnt != $past(gnt)))
    else abort_run("grants did not alternate while both initiators were requesting");

  // drives one request on the falling edge and returns at the edge that grants it.
  task automatic issue(input int p, input bit solo, input logic rd,
                       input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] b,
                       input logic [DATA_W-1:0] d);
    @(negedge clk_i);
    if (solo) begin
      req = '0; // the other initiator stays quiet.
    end
    req[p]  = 1'b1;
    wen[p]  = rd;
    add[p]  = a;
    be[p]   = b;
    data[p] = d;
    @(posedge clk_i);
    while (!gnt[p]) begin
      @(posedge clk_i);
    end
  endtask

  task automatic contend(input int p);
    for (int i = 0; i < RAND_N; i++) begin
      issue(p, 1'b0, rnd_txn[p][i].wen, rnd_txn[p][i].add, rnd_txn[p][i].be,
            rnd_txn[p][i].data);
    end
    @(negedge clk_i);
    req[p] = 1'b0; // stop before the last fields are taken a second time.
  endtask

  // idles until every answer is back and the pipeline holds no filtered write.
  task automatic drain();
    @(negedge clk_i);
    req = '0;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(negedge clk_i);
    end
    repeat (LATENCY) @(negedge clk_i);
  endtask

  initial begin
    void'($urandom(SEED));
    filter_en = 1'b1;
    clear     = 1'b0;
    req       = '0;
    wen       = '0;
    for (int p = 0; p < N_INIT; p++) begin
      add[p]  = '0;
      be[p]   = '0;
      data[p] = '0;
      for (int i = 0; i < RAND_N; i++) rnd_txn[p][i] = random_txn();
    end
    @(posedge rst_ni);

    // fill the words, then read after write with partial byte enables while the filter is on.
    for (int i = 0; i < FILL_WORDS; i++) begin
      issue(0, 1'b1, 1'b0, word_add(i), '1, fill_word(i));
    end
    issue(1, 1'b1, 1'b0, word_add(3), 4'b0101, 32'h1122_3344);
    issue(1, 1'b1, 1'b1, word_add(3), '0, '0);
    issue(0, 1'b1, 1'b0, word_add(3) + ADDR_W'(2), 4'b1000, 32'hCAFE_BABE);
    issue(0, 1'b1, 1'b1, word_add(3), '0, '0);
    issue(1, 1'b1, 1'b1, word_add(9) + ADDR_W'(3), '0, '0);
    drain();

    // with the filter off every transfer is answered, also in a back-to-back burst.
    @(negedge clk_i);
    filter_en = 1'b0;
    issue(0, 1'b1, 1'b0, word_add(7), '1, 32'h0BAD_F00D);
    issue(1, 1'b1, 1'b1, word_add(7), '0, '0);
    issue(1, 1'b1, 1'b0, word_add(2), 4'b0011, 32'h5566_7788);
    issue(0, 1'b1, 1'b1, word_add(2), '0, '0);
    for (int i = 0; i < BURST_N; i++) begin
      t = random_txn();
      issue(0, 1'b1, i[0], t.add, t.be, t.data); // writes and reads take turns.
    end
    drain();

    // both initiators request every cycle with the filter on again.
    @(negedge clk_i);
    filter_en = 1'b1;
    fork
      contend(0);
      contend(1);
    join
    drain();

    // a clear pulse on an idle bank must not stop the reads after it from being answered.
    @(negedge clk_i);
    clear = 1'b1;
    @(negedge clk_i);
    clear = 1'b0;
    issue(1, 1'b1, 1'b1, word_add(5), '0, '0);
    issue(0, 1'b1, 1'b0, word_add(5), 4'b0110, 32'hDEAD_BEEF);
    issue(0, 1'b1, 1'b1, word_add(5), '0, '0);
    drain();

    $display("All tests passed!");
    $finish;
  end

endmodule : tb_tcdm_subsystem

`default_nettype wire

/* all.f */
src/tcdm_pkg.sv
src/tcdm_reg_slice.sv
src/tcdm_arbiter.sv
src/tcdm_r_valid_filter.sv
src/tcdm_sram_bank.sv
src/tcdm_subsystem.sv
bench/tb_clock.sv
bench/tb_tcdm_subsystem.sv
